/* flist.f */
+incdir+testbench
source/fe_pkg.sv
source/instr_scan.sv
source/pc_gen.sv
source/instr_queue.sv
source/frontend_top.sv
testbench/tb_frontend.sv

/* source/fe_pkg.sv */
// fetch front end package
// widths, opcodes, control-flow kinds and the structs shared by the front end
package fe_pkg;

    // ------------------------------
    // widths and sizes
    // ------------------------------
    // address and instruction width
    localparam int XLEN_W = 32;
    // one uncompressed instruction per fetch
    localparam int ILEN_BYTES = 4;
    // default instruction queue depth
    localparam int QUEUE_DEPTH = 4;
    // occupancy counter width, holds 0..QUEUE_DEPTH
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // ------------------------------
    // opcodes seen by the pre-decode
    // ------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // control-flow kind of a fetched instruction
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_kind_e;

    // ------------------------------
    // structs
    // ------------------------------
    // one entry handed to decode, 99 bits
    typedef struct packed {
        logic [XLEN_W-1:0] pc;
        logic [XLEN_W-1:0] instr;
        cf_kind_e          cf;
        logic              pred_taken;
        logic [XLEN_W-1:0] pred_target;
    } fetch_entry_t;

    // control-flow change requests from the back end, 132 bits
    typedef struct packed {
        logic              mispredict;
        logic [XLEN_W-1:0] mispredict_target;
        logic              eret;
        logic [XLEN_W-1:0] epc;
        logic              exception;
        logic [XLEN_W-1:0] trap_vector;
        logic              set_pc_commit;
        logic [XLEN_W-1:0] pc_commit;
    } redirect_t;

    // static prediction for one instruction, 35 bits
    typedef struct packed {
        cf_kind_e          cf;
        logic              pred_taken;
        logic [XLEN_W-1:0] pred_target;
    } scan_result_t;

endpackage

/* source/frontend_top.sv */
// instruction fetch front end top
// ties the PC generator, pre-decode and instruction queue to memory and decode
`timescale 1ns/1ps

module frontend_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [fe_pkg::XLEN_W-1:0] boot_addr_i,
    input  fe_pkg::redirect_t         redirect_i,
    // memory port
    output logic                      fetch_req_o,
    output logic [fe_pkg::XLEN_W-1:0] fetch_addr_o,
    input  logic                      fetch_valid_i,
    input  logic [fe_pkg::XLEN_W-1:0] fetch_data_i,
    // decode port
    output fe_pkg::fetch_entry_t      fetch_entry_o,
    output logic                      fetch_entry_valid_o,
    input  logic                      fetch_entry_ready_i
);
    import fe_pkg::*;

    // accepted response from pc_gen
    logic              rsp_push;
    logic [XLEN_W-1:0] rsp_pc;
    logic [XLEN_W-1:0] rsp_instr;
    logic              flush;
    scan_result_t      scan;
    fetch_entry_t      entry_in;
    logic [CNT_W-1:0]  queue_count;

    // ------------------------------
    // next pc and request control
    // ------------------------------
    pc_gen u_pc_gen (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .boot_addr_i   (boot_addr_i),
        .redirect_i    (redirect_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_data_i  (fetch_data_i),
        .scan_i        (scan),
        .queue_count_i (queue_count),
        .fetch_req_o   (fetch_req_o),
        .fetch_addr_o  (fetch_addr_o),
        .rsp_push_o    (rsp_push),
        .rsp_pc_o      (rsp_pc),
        .rsp_instr_o   (rsp_instr),
        .flush_o       (flush)
    );

    // pre-decode of the returned word
    instr_scan u_instr_scan (
        .instr_i  (rsp_instr),
        .pc_i     (rsp_pc),
        .result_o (scan)
    );

    // queue entry built from the response and its prediction
    assign entry_in.pc          = rsp_pc;
    assign entry_in.instr       = rsp_instr;
    assign entry_in.cf          = scan.cf;
    assign entry_in.pred_taken  = scan.pred_taken;
    assign entry_in.pred_target = scan.pred_target;

    // ------------------------------
    // buffer towards decode
    // ------------------------------
    instr_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_instr_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush),
        .push_i  (rsp_push),
        .entry_i (entry_in),
        .ready_i (fetch_entry_ready_i),
        .entry_o (fetch_entry_o),
        .valid_o (fetch_entry_valid_o),
        .count_o (queue_count)
    );

endmodule

/* source/instr_queue.sv */
// instruction queue
// circular buffer of fetch entries towards decode, flushed on redirect
`timescale 1ns/1ps

module instr_queue #(
    parameter int DEPTH = fe_pkg::QUEUE_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  logic                         push_i,
    input  fe_pkg::fetch_entry_t         entry_i,
    input  logic                         ready_i,
    output fe_pkg::fetch_entry_t         entry_o,
    output logic                         valid_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);
    import fe_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CW    = $clog2(DEPTH + 1);

    // entry storage
    fetch_entry_t   mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CW-1:0]    count_q;

    logic pop;
    logic push_en;
    logic full;

    // ------------------------------
    // handshake
    // ------------------------------
    assign full    = count_q == CW'(DEPTH);
    assign valid_o = count_q != '0;
    assign entry_o = mem_q[rd_ptr_q];
    assign count_o = count_q;

    // decode takes the head entry
    assign pop = valid_o & ready_i;
    // a full queue still accepts when the head leaves this cycle
    assign push_en = push_i & ~flush_i & (~full | pop);

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // a pop in this cycle has already been seen by decode
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (pop) begin
                // explicit wrap, depth need not be a power of two
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (push_en && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

endmodule

/* source/instr_scan.sv */
// instruction pre-decode
// finds branches and JALs in one word and gives a static prediction with its target
`timescale 1ns/1ps

module instr_scan (
    input  logic [fe_pkg::XLEN_W-1:0] instr_i,
    input  logic [fe_pkg::XLEN_W-1:0] pc_i,
    output fe_pkg::scan_result_t      result_o
);
    import fe_pkg::*;

    // major opcode of the word
    logic [6:0] opcode;
    // sign-extended immediates, both formats decoded in parallel
    logic [XLEN_W-1:0] imm_b;
    logic [XLEN_W-1:0] imm_j;
    // candidate targets
    logic [XLEN_W-1:0] target_b;
    logic [XLEN_W-1:0] target_j;

    assign opcode = instr_i[6:0];

    // ------------------------------
    // immediate extraction
    // ------------------------------
    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign imm_b = {
        {(XLEN_W - 12){instr_i[31]}},
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // J-type: imm[20|10:1|11|19:12] in 31:12
    assign imm_j = {
        {(XLEN_W - 20){instr_i[31]}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    // pc-relative targets
    assign target_b = pc_i + imm_b;
    assign target_j = pc_i + imm_j;

    // ------------------------------
    // classification and prediction
    // ------------------------------
    always_comb begin
        // plain instruction by default, no target
        result_o.cf          = CF_NONE;
        result_o.pred_taken  = 1'b0;
        result_o.pred_target = '0;

        case (opcode)
            OPC_BRANCH: begin
                result_o.cf = CF_BRANCH;
                // backward taken, forward not taken
                result_o.pred_taken  = imm_b[XLEN_W-1];
                result_o.pred_target = target_b;
            end
            OPC_JAL: begin
                // unconditional with a known target
                result_o.cf          = CF_JUMP;
                result_o.pred_taken  = 1'b1;
                result_o.pred_target = target_j;
            end
            default: begin
                // jalr, loads, alu ops etc. fall through
                result_o.cf = CF_NONE;
            end
        endcase
    end

endmodule

/* source/pc_gen.sv */
// next-PC generation and fetch request control
// keeps one request in flight, drops stale responses and follows back-end redirects
`timescale 1ns/1ps

module pc_gen (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [fe_pkg::XLEN_W-1:0] boot_addr_i,
    input  fe_pkg::redirect_t         redirect_i,
    input  logic                      fetch_valid_i,
    input  logic [fe_pkg::XLEN_W-1:0] fetch_data_i,
    input  fe_pkg::scan_result_t      scan_i,
    input  logic [fe_pkg::CNT_W-1:0]  queue_count_i,
    output logic                      fetch_req_o,
    output logic [fe_pkg::XLEN_W-1:0] fetch_addr_o,
    output logic                      rsp_push_o,
    output logic [fe_pkg::XLEN_W-1:0] rsp_pc_o,
    output logic [fe_pkg::XLEN_W-1:0] rsp_instr_o,
    output logic                      flush_o
);
    import fe_pkg::*;

    // address of the next request
    logic [XLEN_W-1:0] npc_d, npc_q;
    // set in the first cycle out of reset, boot address is loaded then
    logic              rst_load_q;
    // one request in flight
    logic              outstanding_q;
    // the in-flight request was overtaken by a redirect
    logic              stale_q;
    // pc of the request in flight
    logic [XLEN_W-1:0] req_pc_q;

    logic              redirect_any;
    logic              rsp_ok;
    logic              room;
    logic [CNT_W:0]    occupancy;

    // any back-end flag restarts fetch
    assign redirect_any = redirect_i.mispredict | redirect_i.eret |
                          redirect_i.exception  | redirect_i.set_pc_commit;
    assign flush_o = redirect_any;

    // ------------------------------
    // response handling
    // ------------------------------
    // responses to a redirected request never reach the queue
    assign rsp_ok      = fetch_valid_i & outstanding_q & ~stale_q & ~redirect_any;
    assign rsp_push_o  = rsp_ok;
    assign rsp_pc_o    = req_pc_q;
    assign rsp_instr_o = fetch_data_i;

    // ------------------------------
    // request issue
    // ------------------------------
    // queue slots taken, in-flight request included
    assign occupancy = {1'b0, queue_count_i} + (CNT_W + 1)'(outstanding_q);
    assign room      = occupancy < (CNT_W + 1)'(QUEUE_DEPTH);

    // rst_load_q is set by reset, so no request leaves during reset
    assign fetch_req_o  = ~rst_load_q & ~outstanding_q & ~redirect_any & room;
    assign fetch_addr_o = npc_q;

    // ------------------------------
    // next pc select
    // ------------------------------
    // lowest precedence first, later assignments win
    always_comb begin
        npc_d = npc_q;
        if (rst_load_q) begin
            npc_d = boot_addr_i;
        end
        // follow the static prediction of the returned word
        if (rsp_ok) begin
            if (scan_i.pred_taken) begin
                npc_d = scan_i.pred_target;
            end else begin
                npc_d = req_pc_q + XLEN_W'(ILEN_BYTES);
            end
        end
        // resolved misprediction
        if (redirect_i.mispredict) begin
            npc_d = redirect_i.mispredict_target;
        end
        // return from exception
        if (redirect_i.eret) begin
            npc_d = redirect_i.epc;
        end
        // exception or interrupt
        if (redirect_i.exception) begin
            npc_d = redirect_i.trap_vector;
        end
        // pipeline flush restarts after the committing instruction
        if (redirect_i.set_pc_commit) begin
            npc_d = redirect_i.pc_commit + XLEN_W'(ILEN_BYTES);
        end
    end

    // ------------------------------
    // control state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rst_load_q    <= 1'b1;
            npc_q         <= '0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            rst_load_q <= 1'b0;
            npc_q      <= npc_d;
            // request and response never share a cycle
            if (fetch_req_o) begin
                outstanding_q <= 1'b1;
            end else if (fetch_valid_i) begin
                outstanding_q <= 1'b0;
            end
            // mark stale only while the answer is still pending
            if (fetch_valid_i) begin
                stale_q <= 1'b0;
            end else if (redirect_any && outstanding_q) begin
                stale_q <= 1'b1;
            end
        end
    end

    // remember where the pending word came from
    always_ff @(posedge clk_i) begin
        if (fetch_req_o) begin
            req_pc_q <= npc_q;
        end
    end

endmodule

/* testbench/tb_utils.svh */
// testbench helpers
// random source, memory image, reference pre-decode and value compare
`ifndef TB_UTILS_SVH
`define TB_UTILS_SVH

// ------------------------------
// random source
// ------------------------------
// fibonacci lfsr, taps 32 22 2 1, one step per returned bit
function automatic logic [31:0] next_rand(int nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

// word-aligned address in the low 64 KiB
function automatic logic [31:0] rand_addr();
    return next_rand(14) << 2;
endfunction

// ------------------------------
// memory image
// ------------------------------
// hashed from the whole address, a quarter branches and an eighth JALs
function automatic logic [31:0] image_word(logic [31:0] addr);
    logic [31:0] h;
    h = (addr ^ (addr >> 15)) * 32'h9e37_79b1;
    h = h ^ (h >> 13);
    case (h[2:0])
        // B-type, imm[1] held at zero so targets stay word aligned
        3'd0, 3'd1: return {h[31:9], 1'b0, h[8], 7'b1100011};
        // J-type, imm[1] sits in bit 21
        3'd2:       return {h[31:22], 1'b0, h[20:7], 7'b1101111};
        // plain OP-IMM word
        default:    return {h[31:7], 7'b0010011};
    endcase
endfunction

// ------------------------------
// reference pre-decode
// ------------------------------
function automatic scan_result_t scan_model(logic [31:0] instr, logic [31:0] pc);
    scan_result_t r;
    logic [31:0]  imm;
    r = '0;
    if (instr[6:0] == 7'b1100011) begin
        // conditional branch, backward means taken
        imm           = 32'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
        r.cf          = CF_BRANCH;
        r.pred_taken  = imm[31];
        r.pred_target = pc + imm;
    end else if (instr[6:0] == 7'b1101111) begin
        imm           = 32'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
        r.cf          = CF_JUMP;
        r.pred_taken  = 1'b1;
        r.pred_target = pc + imm;
    end
    return r;
endfunction

// wide enough for a whole fetch entry
task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
        err_count++;
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
endtask

`endif

/* testbench/tb_frontend.sv */
// testbench for the fetch front end
// random memory latency, decode stalls and redirects checked against a pc model
`timescale 1ns/1ps

module tb_frontend;
    import fe_pkg::*;

    localparam logic [31:0] SEED       = 32'h6304_35a3;
    localparam logic [31:0] BOOT_ADDR  = 32'h0000_2000;
    localparam int          NUM_XFERS  = 600;
    localparam int          MAX_CYCLES = 20000;
    localparam int          IDLE_LIMIT = 200;

    logic              clk_i;
    logic              rst_ni;
    logic [XLEN_W-1:0] boot_addr_i;
    redirect_t         redirect_i;
    logic              fetch_req_o;
    logic [XLEN_W-1:0] fetch_addr_o;
    logic              fetch_valid_i;
    logic [XLEN_W-1:0] fetch_data_i;
    fetch_entry_t      fetch_entry_o;
    logic              fetch_entry_valid_o;
    logic              fetch_entry_ready_i;

    logic [31:0]  lfsr_state;
    int           err_count;
    int           xfer_count;
    int           redirect_count;
    int           cycle_count;
    int           reset_cycles;
    int           idle_cycles;
    // pc model
    logic [31:0]  exp_pc;
    // memory responder state, one request at most
    bit           mem_busy;
    bit           mem_stale;
    int           mem_wait;
    logic [31:0]  mem_addr;
    // queue occupancy model
    int           q_count;
    // entry seen while decode stalled
    bit           hold_valid;
    fetch_entry_t hold_entry;

    `include "tb_utils.svh"

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    frontend_top dut0 (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .boot_addr_i         (boot_addr_i),
        .redirect_i          (redirect_i),
        .fetch_req_o         (fetch_req_o),
        .fetch_addr_o        (fetch_addr_o),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_data_i        (fetch_data_i),
        .fetch_entry_o       (fetch_entry_o),
        .fetch_entry_valid_o (fetch_entry_valid_o),
        .fetch_entry_ready_i (fetch_entry_ready_i)
    );

    // ------------------------------
    // stimulus, falling edge
    // ------------------------------
    always @(negedge clk_i) begin
        logic [3:0] flags;
        if (cycle_count > 0) begin
            // memory answers once, 1 to 4 cycles after the request
            fetch_valid_i = 1'b0;
            if (mem_busy && mem_wait > 0) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    fetch_valid_i = 1'b1;
                    fetch_data_i  = image_word(mem_addr);
                end
            end
            // long decode stalls every third window of 40 cycles
            if ((cycle_count / 40) % 3 == 2) begin
                fetch_entry_ready_i = 1'b0;
            end else begin
                fetch_entry_ready_i = next_rand(2) != 0;
            end
            // rare redirects, often several flags at once
            redirect_i = '0;
            if (cycle_count > 20 && next_rand(5) == 0) begin
                flags = 4'(next_rand(4));
                if (flags == 4'b0000) begin
                    flags = 4'b0001;
                end
                redirect_i.mispredict        = flags[0];
                redirect_i.mispredict_target = rand_addr();
                redirect_i.eret              = flags[1];
                redirect_i.epc               = rand_addr();
                redirect_i.exception         = flags[2];
                redirect_i.trap_vector       = rand_addr();
                redirect_i.set_pc_commit     = flags[3];
                redirect_i.pc_commit         = rand_addr();
            end
        end
    end

    // ------------------------------
    // model and checks, rising edge
    // ------------------------------
    always @(posedge clk_i) begin
        logic         redir;
        logic         pop;
        logic         push;
        scan_result_t exp_scan;
        if (!rst_ni) begin
            // DUT state is unknown until the first edge in reset
            if (reset_cycles > 0) begin
                check_val("fetch_req_o", fetch_req_o, 1'b0);
                check_val("fetch_entry_valid_o", fetch_entry_valid_o, 1'b0);
            end
            reset_cycles++;
        end else begin
            cycle_count++;
            redir = redirect_i.mispredict | redirect_i.eret |
                    redirect_i.exception | redirect_i.set_pc_commit;
            pop   = fetch_entry_valid_o & fetch_entry_ready_i;
            push  = fetch_valid_i & mem_busy & ~mem_stale & ~redir;
            check_val("fetch_entry_valid_o", fetch_entry_valid_o, q_count != 0);
            // stalled head must not move
            if (hold_valid) begin
                check_val("fetch_entry_o", fetch_entry_o, hold_entry);
            end
            // one request at most, and only with room for its answer
            if (fetch_req_o) begin
                check_val("outstanding request count", mem_busy, 1'b0);
                check_val("queue room at fetch_req_o", q_count < QUEUE_DEPTH, 1'b1);
                check_val("redirect at fetch_req_o", redir, 1'b0);
            end
            if (pop) begin
                exp_scan = scan_model(image_word(exp_pc), exp_pc);
                check_val("fetch_entry_o.pc", fetch_entry_o.pc, exp_pc);
                check_val("fetch_entry_o.instr", fetch_entry_o.instr, image_word(exp_pc));
                check_val("fetch_entry_o.cf", fetch_entry_o.cf, exp_scan.cf);
                check_val("fetch_entry_o.pred_taken", fetch_entry_o.pred_taken,
                          exp_scan.pred_taken);
                if (exp_scan.cf != CF_NONE) begin
                    check_val("fetch_entry_o.pred_target", fetch_entry_o.pred_target,
                              exp_scan.pred_target);
                end
                exp_pc      = exp_scan.pred_taken ? exp_scan.pred_target : exp_pc + 32'd4;
                xfer_count++;
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
            // redirect precedence, commit flush highest
            if (redir) begin
                redirect_count++;
                if (redirect_i.set_pc_commit) begin
                    exp_pc = redirect_i.pc_commit + 32'd4;
                end else if (redirect_i.exception) begin
                    exp_pc = redirect_i.trap_vector;
                end else if (redirect_i.eret) begin
                    exp_pc = redirect_i.epc;
                end else begin
                    exp_pc = redirect_i.mispredict_target;
                end
            end
            // in-flight request bookkeeping
            if (fetch_valid_i) begin
                mem_busy  = 1'b0;
                mem_stale = 1'b0;
            end else if (redir && mem_busy) begin
                mem_stale = 1'b1;
            end
            if (fetch_req_o) begin
                mem_busy = 1'b1;
                mem_wait = 1 + int'(next_rand(2));
                mem_addr = fetch_addr_o;
            end
            q_count    = redir ? 0 : q_count + int'(push) - int'(pop);
            hold_valid = fetch_entry_valid_o & ~fetch_entry_ready_i & ~redir;
            hold_entry = fetch_entry_o;
        end
    end

    // ------------------------------
    // run control
    // ------------------------------
    initial begin
        int wait_cycles;
        lfsr_state          = SEED;
        err_count           = 0;
        xfer_count          = 0;
        redirect_count      = 0;
        cycle_count         = 0;
        reset_cycles        = 0;
        idle_cycles         = 0;
        mem_busy            = 1'b0;
        mem_stale           = 1'b0;
        mem_wait            = 0;
        mem_addr            = '0;
        q_count             = 0;
        hold_valid          = 1'b0;
        hold_entry          = '0;
        exp_pc              = BOOT_ADDR;
        rst_ni              = 1'b0;
        boot_addr_i         = BOOT_ADDR;
        redirect_i          = '0;
        fetch_valid_i       = 1'b0;
        fetch_data_i        = '0;
        fetch_entry_ready_i = 1'b0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        wait_cycles = 0;
        while (xfer_count < NUM_XFERS && wait_cycles < MAX_CYCLES &&
               idle_cycles < IDLE_LIMIT) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (xfer_count < NUM_XFERS) begin
            err_count++;
            if (idle_cycles >= IDLE_LIMIT) begin
                $display("Timeout: no entry reached decode for %0d cycles", idle_cycles);
            end else begin
                $display("Timeout: only %0d of %0d entries reached decode",
                         xfer_count, NUM_XFERS);
            end
        end
        $display("transfers %0d, redirects %0d, errors %0d",
                 xfer_count, redirect_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
